// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = b1Tb
FILELIST = verilog.f
LOG = sim.log

BIN = obj_dir/V$(TOP)
SRCS = $(wildcard *.sv *.svh) $(FILELIST)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "SIMULATION FAILED" $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== b1Pkg.sv ====
`default_nettype none

`include "b1_defines.svh"

package b1Pkg;

	// Pixel position on the line
	typedef logic [`X_BITS-1:0] xPosT;

	// Palette RAM address
	typedef logic [11:0] palAddrT;

	// Line buffer entry
	// Packed palette first, so the entry is already a palette address
	typedef struct packed {
		logic [7:0] palette;
		logic [3:0] colour;	// 0 is transparent
	} lbEntryT;

	// Watchdog counters
	typedef logic [$clog2(`WD_LIMIT)-1:0] wdCntT;
	typedef logic [$clog2(`WD_PULSE)-1:0] pulseCntT;

endpackage

`default_nettype wire

// ==== b1Tb.sv ====
`default_nettype none

`include "b1_defines.svh"

module b1Tb import b1Pkg::*; ();

	localparam int LINE = `LINE_PIXELS;
	localparam int TIMEOUT = (8 * 330 + 3000) * 3 / 2;	// Tests plus margin

	wire S1H1;
	wire nS1H1;
	logic lineStart, spriteLoad, pixelValid, blank, asN, ldsN, rw;
	xPosT spriteX;
	logic [7:0] spritePal;
	logic [3:0] gad, gbd, fixPixel, fixPal;
	logic [23:1] cpuAddr;
	palAddrT pa;
	logic resetOut;

	// Reference model state
	lbEntryT mA [LINE];
	lbEntryT mB [LINE];
	logic mSel;			// High while B is front
	int mRd;
	xPosT mX;
	logic [7:0] mPal;
	palAddrT expQ[$];		// pa two cycles out
	int wdCnt, pulseLeft;
	logic wdOut;
	int errors = 0, checks = 0, cycles = 0, errMark;
	logic [31:0] seed = 32'd82810;

	tbClock uClock (.S1H1(S1H1), .nS1H1(nS1H1));

	b1Top DUT (.*);

	function automatic logic [31:0] lcg();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed >> 8;	// Low bits are weak
	endfunction

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %s got %h expected %h, cycle %0d", name, got, exp, cycles);
		end
	endtask

	task automatic idle();
		lineStart = 1'b0;
		spriteLoad = 1'b0;
		pixelValid = 1'b0;
		blank = 1'b0;
		asN = 1'b1;		// Bus idle
		ldsN = 1'b1;
		rw = 1'b1;
		cpuAddr = '0;
		spriteX = '0;
		spritePal = '0;
		gad = '0;
		gbd = '0;
		fixPixel = '0;
		fixPal = '0;
	endtask

	// 68000 byte write for one slot
	task automatic cpuWrite(logic [23:1] addr);
		asN = 1'b0;
		ldsN = 1'b0;
		rw = 1'b0;
		cpuAddr = addr;
	endtask

	task automatic putBack(int x, lbEntryT e);
		if (mSel)
			mA[x] = e;		// A is back while B is front
		else
			mB[x] = e;
	endtask

	// One pixel slot with model, edge and checks
	task automatic tick();
		lbEntryT spr;
		palAddrT exp;
		logic kick;
		spr = '0;
		if (lineStart)
		begin
			mSel = !mSel;
			mRd = 0;
		end
		else if (mRd < LINE)
		begin
			spr = mSel ? mB[mRd] : mA[mRd];
			if (mSel)		// Read clears
				mB[mRd] = '0;
			else
				mA[mRd] = '0;
			mRd++;
		end
		if (spriteLoad)
		begin
			mX = spriteX & ~xPosT'(1);
			mPal = spritePal;
		end
		else if (pixelValid)
		begin
			if (int'(mX) < LINE && gad != 0)
				putBack(int'(mX), {mPal, gad});
			if (int'(mX) < LINE && gbd != 0)
				putBack(int'(mX) + 1, {mPal, gbd});
			mX = mX + xPosT'(2);
		end
		// Palette address priority
		if (!asN && cpuAddr[23:22] == 2'b01)
			exp = cpuAddr[12:1];
		else if (blank)
			exp = '0;
		else if (fixPixel != 0)
			exp = {4'd0, fixPal, fixPixel};
		else
			exp = spr;
		expQ.push_back(exp);
		kick = !asN && !ldsN && !rw && (cpuAddr[23:17] == `WD_KICK_HI);
		@(posedge S1H1);
		if (pulseLeft > 0)
		begin
			pulseLeft--;
			if (pulseLeft == 0)
			begin
				wdOut = 1'b0;
				wdCnt = 0;
			end
		end
		else if (kick)
			wdCnt = 0;
		else
		begin
			wdCnt++;
			if (wdCnt == `WD_LIMIT)
			begin
				wdOut = 1'b1;		// Expired
				pulseLeft = `WD_PULSE;
			end
		end
		#1;
		cycles++;
		if (cycles > TIMEOUT)
		begin
			$display("Timeout: run went past %0d cycles", TIMEOUT);
			$display("SIMULATION FAILED");
			$finish;
		end
		check("resetOut", 32'(resetOut), 32'(wdOut));
		if (expQ.size() == 2)
			check("pa", 32'(pa), 32'(expQ.pop_front()));
		idle();
	endtask

	task automatic drawSprites(int n);
		repeat (n)
		begin
			spriteLoad = 1'b1;
			spriteX = xPosT'(lcg() % LINE);
			spritePal = 8'(lcg());
			tick();
			repeat (8)
			begin
				pixelValid = 1'b1;
				gad = (lcg() % 3 == 0) ? 4'd0 : 4'(lcg());	// Some transparent
				gbd = (lcg() % 3 == 0) ? 4'd0 : 4'(lcg());
				tick();
			end
		end
		repeat (2) tick();	// Writes settle before lineStart
	endtask

	// Mode 1 adds the fix layer and mode 2 adds blank and CPU cycles
	task automatic renderLine(int mode);
		lineStart = 1'b1;
		tick();
		repeat (LINE + 2)
		begin
			if (mode > 0)
			begin
				fixPixel = (lcg() % 2 != 0) ? 4'(lcg()) : 4'd0;
				fixPal = 4'(lcg());
			end
			if (mode == 2)
			begin
				blank = (lcg() % 3 == 0);
				if (lcg() % 5 == 0)
				begin
					asN = 1'b0;
					rw = 1'(lcg());
					ldsN = 1'(lcg());
					cpuAddr = {2'b01, 21'(lcg())};	// Palette region
				end
			end
			tick();
		end
	endtask

	task automatic report(string name);
		$display("Test %s: %0d errors", name, errors - errMark);
		errMark = errors;
	endtask

	initial
	begin
		int n;
		idle();
		for (int i = 0; i < LINE; i++)
		begin
			mA[i] = '0;
			mB[i] = '0;
		end
		mSel = 1'b0;		// A front after reset
		mRd = LINE;
		mX = '0;
		mPal = '0;
		wdCnt = 0;
		pulseLeft = 0;
		wdOut = 1'b0;
		errMark = 0;
		@(negedge nS1H1);

		drawSprites(6);
		renderLine(0);
		report("sprite rendering");

		renderLine(0);		// Empty bank
		renderLine(0);		// Bank cleared by the last read
		report("read and clear");

		drawSprites(6);
		renderLine(1);
		report("fix priority");

		drawSprites(6);
		renderLine(2);
		report("blank and CPU priority");

		while (wdOut)
			tick();
		repeat (4)
		begin
			cpuWrite({`WD_KICK_HI, 16'(lcg())});
			tick();
			repeat (500) tick();	// Well inside the limit
		end
		cpuWrite({`WD_KICK_HI, 16'(lcg())});
		tick();			// Last kick
		cpuWrite({7'b0011001, 16'(lcg())});	// Outside the kick region
		tick();
		n = 1;
		while (!resetOut && n < 1200)
		begin
			tick();
			n++;
		end
		check("riseDelay", n, `WD_LIMIT);
		n = 0;
		while (resetOut && n < 100)
		begin
			n++;
			tick();
		end
		check("pulseLen", n, `WD_PULSE);
		report("watchdog");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== b1Top.sv ====
`default_nettype none

module b1Top import b1Pkg::*; (
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire logic lineStart,
	input wire logic spriteLoad,
	input wire xPosT spriteX,
	input wire logic [7:0] spritePal,
	input wire logic pixelValid,
	input wire logic [3:0] gad,
	input wire logic [3:0] gbd,
	input wire logic [3:0] fixPixel,
	input wire logic [3:0] fixPal,
	input wire logic blank,
	input wire logic asN,
	input wire logic ldsN,
	input wire logic rw,
	input wire logic [23:1] cpuAddr,
	output palAddrT pa,
	output logic resetOut
);

	spriteWriteIf sprWr ();		// Decode to line buffer
	lbEntryT spriteEntry;
	logic palAccess;

	spriteDecode uSpriteDecode (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.spriteLoad(spriteLoad),
		.spriteX(spriteX),
		.spritePal(spritePal),
		.pixelValid(pixelValid),
		.gad(gad),
		.gbd(gbd),
		.wr(sprWr.src)
	);

	cpuDecode uCpuDecode (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.asN(asN),
		.ldsN(ldsN),
		.rw(rw),
		.cpuAddr(cpuAddr),
		.palAccess(palAccess),
		.resetOut(resetOut)
	);

	lineBuffer uLineBuffer (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.lineStart(lineStart),
		.wr(sprWr.dst),
		.spriteEntry(spriteEntry)
	);

	paletteSelect uPaletteSelect (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.spriteEntry(spriteEntry),
		.fixPixel(fixPixel),
		.fixPal(fixPal),
		.blank(blank),
		.palAccess(palAccess),
		.cpuPalAddr(cpuAddr[12:1]),	// Palette word address
		.pa(pa)
	);

endmodule

`default_nettype wire

// ==== b1_defines.svh ====
`ifndef B1_DEFINES_SVH
`define B1_DEFINES_SVH

// Visible pixels per line, one line buffer bank each
`define LINE_PIXELS 320

// Pixel position width
`define X_BITS 9

// Watchdog kick region, CPU address bits 23:17
`define WD_KICK_HI 7'b0011000

// Palette RAM region, CPU address bits 23:22
`define PAL_HI 2'b01

`define WD_LIMIT 1024	// Cycles without kick before reset
`define WD_PULSE 16		// Reset output length

`endif

// ==== b1_properties.sv ====
`default_nettype none

`include "b1_defines.svh"

module b1Props (
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire logic [11:0] pa,
	input wire logic resetOut,
	input wire logic asN,
	input wire logic ldsN,
	input wire logic rw,
	input wire logic [23:1] cpuAddr
);

	logic kick;
	logic [11:0] sinceKick;	// Saturating
	logic [7:0] highLen;		// Cycles of resetOut so far

	assign kick = !asN && !ldsN && !rw && (cpuAddr[23:17] == `WD_KICK_HI);

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			sinceKick <= '0;
			highLen <= '0;
		end
		else
		begin
			if (kick && !resetOut)
				sinceKick <= '0;
			else if (sinceKick != 12'hfff)
				sinceKick <= sinceKick + 1'b1;
			highLen <= resetOut ? highLen + 1'b1 : 8'd0;
		end
	end

	// Outputs quiet in reset
	resetQuiet: assert property (@(posedge S1H1) nS1H1 |-> (pa == '0 && !resetOut))
		else $error("pa or resetOut active during reset");

	// Pulse length exact
	pulseLength: assert property (@(posedge S1H1) disable iff (nS1H1)
		$fell(resetOut) |-> highLen == 8'(`WD_PULSE))
		else $error("resetOut pulse length wrong");

	// No expiry too soon after a kick
	kickHolds: assert property (@(posedge S1H1) disable iff (nS1H1)
		$rose(resetOut) |-> sinceKick >= 12'(`WD_LIMIT))
		else $error("resetOut rose too soon after a kick");

endmodule

bind b1Top b1Props uProps (.*);

`default_nettype wire

// ==== cpuDecode.sv ====
`default_nettype none

`include "b1_defines.svh"

module cpuDecode import b1Pkg::*; (
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire logic asN,			// 68000 address strobe
	input wire logic ldsN,			// Lower data strobe
	input wire logic rw,				// High for read
	input wire logic [23:1] cpuAddr,
	output logic palAccess,		// Palette RAM cycle, combinational
	output logic resetOut
);

	logic kick;
	wdCntT wdCnt;			// Cycles since last kick
	pulseCntT pulseCnt;		// Cycles of reset output so far

	// Palette region, read or write
	assign palAccess = !asN && (cpuAddr[23:22] == `PAL_HI);

	// Byte write into the watchdog region
	assign kick = !asN && !ldsN && !rw && (cpuAddr[23:17] == `WD_KICK_HI);

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			wdCnt <= '0;
			pulseCnt <= '0;
			resetOut <= 1'b0;
		end
		else if (resetOut)
		begin
			// Kicks ignored while pulsing
			if (pulseCnt == pulseCntT'(`WD_PULSE - 1))
			begin
				resetOut <= 1'b0;
				wdCnt <= '0;		// Fresh timeout after the pulse
			end
			else
				pulseCnt <= pulseCnt + 1'b1;
		end
		else if (kick)
			wdCnt <= '0;
		else if (wdCnt == wdCntT'(`WD_LIMIT - 1))
		begin
			resetOut <= 1'b1;		// Expired
			pulseCnt <= '0;
		end
		else
			wdCnt <= wdCnt + 1'b1;
	end

endmodule

`default_nettype wire

// ==== lineBuffer.sv ====
`default_nettype none

`include "b1_defines.svh"

module lineBuffer import b1Pkg::*; (
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire logic lineStart,		// Swap banks, restart readout
	spriteWriteIf.dst wr,
	output lbEntryT spriteEntry		// Front bank pixel, one cycle after address
);

	lbEntryT bankA [`LINE_PIXELS];
	lbEntryT bankB [`LINE_PIXELS];
	logic bankSel;			// 0: A front, B back
	xPosT rdPos;			// Parks at LINE_PIXELS when done
	xPosT oddAddr;
	logic wrOk;
	logic rdOk;

	assign oddAddr = {wr.addr[`X_BITS-1:1], 1'b1};
	assign wrOk = wr.addr < xPosT'(`LINE_PIXELS);	// Pairs past the edge dropped
	assign rdOk = rdPos < xPosT'(`LINE_PIXELS);

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			for (int i = 0; i < `LINE_PIXELS; i++)
			begin
				bankA[i] <= '0;
				bankB[i] <= '0;
			end
			bankSel <= 1'b0;
			rdPos <= xPosT'(`LINE_PIXELS);	// Idle until first line
			spriteEntry <= '0;
		end
		else
		begin
			// Sprite writes, back bank only
			if (wrOk && bankSel)
			begin
				if (wr.weEven)
					bankA[wr.addr] <= wr.entryEven;
				if (wr.weOdd)
					bankA[oddAddr] <= wr.entryOdd;
			end
			else if (wrOk)
			begin
				if (wr.weEven)
					bankB[wr.addr] <= wr.entryEven;
				if (wr.weOdd)
					bankB[oddAddr] <= wr.entryOdd;
			end

			// Readout; position 0 addressed the cycle after lineStart
			if (lineStart)
			begin
				bankSel <= !bankSel;
				rdPos <= '0;
				spriteEntry <= '0;
			end
			else if (rdOk)
			begin
				if (bankSel)
				begin
					spriteEntry <= bankB[rdPos];
					bankB[rdPos] <= '0;	// Cleared for the next fill
				end
				else
				begin
					spriteEntry <= bankA[rdPos];
					bankA[rdPos] <= '0;
				end
				rdPos <= rdPos + 1'b1;
			end
			else
				spriteEntry <= '0;		// Past the line end
		end
	end

endmodule

`default_nettype wire

// ==== paletteSelect.sv ====
`default_nettype none

module paletteSelect import b1Pkg::*; (
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire lbEntryT spriteEntry,		// Already one stage late
	input wire logic [3:0] fixPixel,
	input wire logic [3:0] fixPal,
	input wire logic blank,
	input wire logic palAccess,
	input wire palAddrT cpuPalAddr,		// CPU address bits 12:1
	output palAddrT pa
);

	// Inputs delayed to line up with spriteEntry
	logic [3:0] fixPixelQ;
	logic [3:0] fixPalQ;
	logic blankQ;
	logic palAccessQ;
	palAddrT cpuPalAddrQ;

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			blankQ <= 1'b0;
			palAccessQ <= 1'b0;
			pa <= '0;
		end
		else
		begin
			blankQ <= blank;
			palAccessQ <= palAccess;
			if (palAccessQ)
				pa <= cpuPalAddrQ;		// CPU wins even in blanking
			else if (blankQ)
				pa <= '0;
			else if (fixPixelQ != 4'd0)
				pa <= {4'd0, fixPalQ, fixPixelQ};	// Opaque fix over sprites
			else
				pa <= {spriteEntry.palette, spriteEntry.colour};
		end
	end

	// Data side of the delay stage
	always_ff @(posedge S1H1)
	begin
		fixPixelQ <= fixPixel;
		fixPalQ <= fixPal;
		cpuPalAddrQ <= cpuPalAddr;
	end

endmodule

`default_nettype wire

// ==== spriteDecode.sv ====
`default_nettype none

module spriteDecode import b1Pkg::*; (
	input wire logic S1H1,
	input wire logic nS1H1,
	input wire logic spriteLoad,		// Latch X and palette
	input wire xPosT spriteX,
	input wire logic [7:0] spritePal,
	input wire logic pixelValid,		// One pixel pair this cycle
	input wire logic [3:0] gad,		// Even pixel colour
	input wire logic [3:0] gbd,		// Odd pixel colour
	spriteWriteIf.src wr
);

	xPosT curX;					// Position of next pair
	logic [7:0] curPal;		// Held for the whole sprite
	logic pairValid;

	// Load cycle carries no pixels
	assign pairValid = pixelValid && !spriteLoad;

	// Position and write strobes
	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			curX <= '0;
			wr.weEven <= 1'b0;
			wr.weOdd <= 1'b0;
		end
		else
		begin
			// Colour 0 never written, earlier sprite stays visible
			wr.weEven <= pairValid && (gad != 4'd0);
			wr.weOdd <= pairValid && (gbd != 4'd0);
			if (spriteLoad)
				curX <= spriteX & ~xPosT'(1);	// Pairs sit on even X
			else if (pairValid)
				curX <= curX + xPosT'(2);		// Next pair
		end
	end

	// Palette latch
	always_ff @(posedge S1H1)
	begin
		if (spriteLoad)
			curPal <= spritePal;
	end

	// Request payload, qualified by the strobes above
	always_ff @(posedge S1H1)
	begin
		wr.addr <= curX;
		wr.entryEven <= lbEntryT'{palette: curPal, colour: gad};
		wr.entryOdd <= lbEntryT'{palette: curPal, colour: gbd};
	end

endmodule

`default_nettype wire

// ==== spriteWriteIf.sv ====
`default_nettype none

// Sprite pixel pair write into the back bank
interface spriteWriteIf import b1Pkg::*; ();

	logic weEven;			// One cycle strobe, no ack
	logic weOdd;
	xPosT addr;				// Even pixel of the pair
	lbEntryT entryEven;
	lbEntryT entryOdd;

	modport src (output weEven, weOdd, addr, entryEven, entryOdd);
	modport dst (input weEven, weOdd, addr, entryEven, entryOdd);

endinterface

`default_nettype wire

// ==== tbClock.sv ====
`default_nettype none

// Clock and power-on reset for the testbench
module tbClock (
	output logic S1H1,
	output logic nS1H1
);

	initial
	begin
		S1H1 = 1'b0;
		forever
			#5 S1H1 = !S1H1;	// Period 10
	end

	initial
	begin
		nS1H1 = 1'b1;
		repeat (8) @(posedge S1H1);
		#1 nS1H1 = 1'b0;		// Released just after an edge
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
b1Pkg.sv
spriteWriteIf.sv
spriteDecode.sv
cpuDecode.sv
lineBuffer.sv
paletteSelect.sv
b1Top.sv
b1_properties.sv
tbClock.sv
b1Tb.sv
